// ==== build.f ====
hdl/oldland_pkg.sv
hdl/oldland_decode.sv
hdl/oldland_issue_queue.sv
hdl/oldland_regfile.sv
hdl/oldland_exec.sv
hdl/oldland_exec_top.sv
tests/tb_oldland_exec.sv

// ==== tests/tb_oldland_exec.sv ====
module tb_oldland_exec;

	timeunit 1ns;
	timeprecision 100ps;

	import oldland_pkg::*;

	localparam int TIMEOUT = 2000;

	typedef struct packed {
		word_t    value;
		word_t    alu;
		reg_sel_t rd;
		logic     taken;
	} result_t;

	logic     clk;
	logic     reset;
	logic     in_valid;
	logic     in_ready;
	word_t    in_instr;
	logic     res_valid;
	logic     res_ready;
	word_t    res_value;
	word_t    res_alu;
	reg_sel_t res_rd;
	logic     res_branch_taken;

	// Reference state follows the architectural state of the core
	word_t   ref_regs [NUM_REGS];
	logic    ref_c;
	logic    ref_z;
	word_t   ref_pc;
	result_t exp_q [$];

	logic  random_ready;
	string cur_test;
	int    test_num;
	int    errors;
	int    errors_at_start;
	int    tests_ok;
	int    tests_bad;

	oldland_exec_top i_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_value(res_value),
		.res_alu(res_alu),
		.res_rd(res_rd),
		.res_branch_taken(res_branch_taken)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		#1;
		if (random_ready)
			res_ready = ($urandom_range(3) != 0);
		else
			res_ready = 1'b1;
	end

	function automatic result_t ref_exec(input word_t instr);
		instr_class_t cls;
		logic [3:0]   opc;
		reg_sel_t     rd;
		word_t        imm;
		word_t        op1;
		word_t        op2;
		word_t        q;
		logic [63:0]  wide;
		logic [4:0]   sh;
		logic         c;
		logic         met;
		result_t      r;
		cls = instr_class_t'(instr[31:30]);
		opc = instr[29:26];
		rd = instr[25:23];
		imm = {{17{instr[14]}}, instr[14:0]};
		ref_pc = ref_pc + 32'd4;
		op1 = instr[16] ? ref_regs[instr[22:20]] : ref_pc;
		op2 = instr[15] ? ref_regs[instr[19:17]] : imm;
		sh = op2[4:0];
		c = 1'b0;
		wide = '0;
		case (opc)
		ADD:   wide = {32'd0, op1} + {32'd0, op2};
		ADDC:  wide = {32'd0, op1} + {32'd0, op2} + {63'd0, ref_c};
		SUB:   wide = {32'd0, op1} - {32'd0, op2};
		SUBC:  wide = {32'd0, op1} - {32'd0, op2} + {63'd0, ref_c};
		LSL:   wide = {32'd0, op1} << sh;
		LSR:   wide = {32'd0, op1 >> sh};
		AND:   wide = {32'd0, op1 & op2};
		XOR:   wide = {32'd0, op1 ^ op2};
		BIC:   wide = {32'd0, op1 & ~(32'd1 << sh)};
		BST:   wide = {32'd0, op1 | (32'd1 << sh)};
		OR:    wide = {32'd0, op1 | op2};
		MOVHI: wide = {32'd0, 32'(instr[14:0]) << 16};
		ASR:   wide = {32'd0, word_t'($signed(op1) >>> sh)};
		COPY:  wide = {32'd0, op1};
		default: wide = '0;
		endcase
		q = wide[31:0];
		// Only the add, subtract and left shift forms produce a carry
		if (opc inside {ADD, ADDC, SUB, SUBC, LSL})
			c = wide[32];
		case (rd)
		ALWAYS:  met = 1'b1;
		NE:      met = !ref_z;
		EQ:      met = ref_z;
		CC:      met = !ref_c;
		CS:      met = ref_c;
		default: met = 1'b0;
		endcase
		r.alu = q;
		r.taken = (cls == BRANCH) && met;
		r.value = (cls == CALL) ? ref_pc : q;
		r.rd = (cls == CALL) ? LINK_REG : rd;
		if (cls != BRANCH)
			ref_regs[r.rd] = r.value;
		if (cls == ARITH) begin
			ref_c = c;
			ref_z = (op1 == op2);
		end
		return r;
	endfunction

	function automatic word_t make_instr(input instr_class_t cls, input logic [3:0] opc,
			input logic [2:0] rd, input reg_sel_t ra, input reg_sel_t rb,
			input logic op1_ra, input logic op2_rb, input logic [14:0] imm);
		return {cls, opc, rd, ra, rb, op1_ra, op2_rb, imm};
	endfunction

	function automatic reg_sel_t rand_reg();
		return reg_sel_t'($urandom_range(NUM_REGS - 1));
	endfunction

	function automatic logic [14:0] rand_imm();
		return 15'($urandom);
	endfunction

	task automatic check_word(input string field, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Error %s %s: expected %h, actual %h", cur_test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg(input string field, input reg_sel_t exp, input reg_sel_t act);
		if (exp !== act) begin
			$display("Error %s %s: expected %0d, actual %0d", cur_test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string field, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error %s %s: expected %b, actual %b", cur_test, field, exp, act);
			errors++;
		end
	endtask

	// Handshakes are sampled mid-cycle, where every signal has settled
	always @(negedge clk) begin : compare_results
		result_t e;
		if (!reset && res_valid && res_ready) begin
			if (exp_q.size() == 0) begin
				$display("Result arrived in %s with no instruction outstanding", cur_test);
				errors++;
			end else begin
				e = exp_q.pop_front();
				check_word("res_value", e.value, res_value);
				check_word("res_alu", e.alu, res_alu);
				check_reg("res_rd", e.rd, res_rd);
				check_bit("res_branch_taken", e.taken, res_branch_taken);
			end
		end
	end

	task automatic timed_out(input string what);
		$display("timed out waiting for %s", what);
		$display("test failed");
		$finish;
	endtask

	task automatic send_instr(input word_t instr);
		int cycles;
		in_valid = 1'b1;
		in_instr = instr;
		cycles = 0;
		@(negedge clk);
		while (!in_ready) begin
			cycles++;
			if (cycles > TIMEOUT)
				timed_out("in_ready");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		exp_q.push_back(ref_exec(instr));
		in_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		test_num++;
		cur_test = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				timed_out("all results of the test to arrive");
		end
		@(posedge clk);
		#1;
		if (errors == errors_at_start) begin
			$display("[%0d] %s: ok", test_num, cur_test);
			tests_ok++;
		end else begin
			$display("[%0d] %s: %0d mismatches", test_num, cur_test, errors - errors_at_start);
			tests_bad++;
		end
	endtask

	task automatic load_reg(input reg_sel_t r);
		send_instr(make_instr(MISC, MOVHI, r, 3'd0, 3'd0, 1'b1, 1'b0, rand_imm()));
		send_instr(make_instr(MISC, XOR, r, r, 3'd0, 1'b1, 1'b0, rand_imm()));
	endtask

	// Leaves r1 holding all ones
	task automatic set_all_ones();
		send_instr(make_instr(MISC, CLR, 3'd1, 3'd0, 3'd0, 1'b1, 1'b0, 15'd0));
		send_instr(make_instr(MISC, XOR, 3'd1, 3'd1, 3'd0, 1'b1, 1'b0, 15'h7fff));
	endtask

	task automatic reset_checks();
		@(negedge clk);
		check_bit("res_valid", 1'b0, res_valid);
		check_bit("in_ready", 1'b1, in_ready);
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_REGS; i++)
			send_instr(make_instr(MISC, COPY, 3'(i), 3'(i), 3'd0, 1'b1, 1'b0, 15'd0));
	endtask

	task automatic alu_sweep();
		for (int r = 0; r < NUM_REGS; r++)
			load_reg(reg_sel_t'(r));
		for (int opc = 0; opc < 16; opc++) begin
			send_instr(make_instr(ARITH, 4'(opc), rand_reg(), rand_reg(), rand_reg(),
				1'b1, 1'b1, rand_imm()));
			send_instr(make_instr(ARITH, 4'(opc), rand_reg(), rand_reg(), rand_reg(),
				1'b1, 1'b0, rand_imm()));
			send_instr(make_instr(ARITH, 4'(opc), rand_reg(), rand_reg(), rand_reg(),
				1'b0, 1'b1, rand_imm()));
		end
	endtask

	task automatic carry_chain();
		set_all_ones();
		send_instr(make_instr(ARITH, ADD, 3'd2, 3'd1, 3'd0, 1'b1, 1'b0, 15'd1));
		send_instr(make_instr(ARITH, ADDC, 3'd3, 3'd1, 3'd0, 1'b1, 1'b0, 15'd0));
		send_instr(make_instr(ARITH, SUBC, 3'd4, 3'd2, 3'd0, 1'b1, 1'b0, 15'd1));
		send_instr(make_instr(ARITH, SUB, 3'd5, 3'd2, 3'd1, 1'b1, 1'b1, 15'd0));
		// MISC ops in between must leave C and Z alone
		send_instr(make_instr(MISC, SUB, 3'd6, 3'd1, 3'd1, 1'b1, 1'b1, 15'd0));
		send_instr(make_instr(ARITH, ADDC, 3'd6, 3'd2, 3'd0, 1'b1, 1'b0, 15'd0));
		send_instr(make_instr(BRANCH, ADD, CS, 3'd0, 3'd0, 1'b0, 1'b0, 15'd8));
		send_instr(make_instr(ARITH, SUB, 3'd0, 3'd1, 3'd1, 1'b1, 1'b1, 15'd0));
		send_instr(make_instr(MISC, XOR, 3'd6, 3'd1, 3'd2, 1'b1, 1'b1, 15'd0));
		send_instr(make_instr(BRANCH, ADD, EQ, 3'd0, 3'd0, 1'b0, 1'b0, 15'd12));
		send_instr(make_instr(ARITH, SUBC, 3'd7, 3'd1, 3'd2, 1'b1, 1'b1, 15'd0));
	endtask

	task automatic branch_conds();
		set_all_ones();
		for (int setup = 0; setup < 2; setup++) begin
			for (int cond = 0; cond < 8; cond++) begin
				if (setup == 0)
					send_instr(make_instr(ARITH, SUB, 3'd3, 3'd1, 3'd1, 1'b1, 1'b1, 15'd0));
				else
					send_instr(make_instr(ARITH, ADD, 3'd2, 3'd1, 3'd0, 1'b1, 1'b0, 15'd2));
				send_instr(make_instr(BRANCH, ADD, 3'(cond), 3'd0, 3'd0, 1'b0, 1'b0,
					rand_imm()));
			end
		end
	endtask

	task automatic call_link();
		send_instr(make_instr(CALL, ADD, 3'd0, 3'd0, 3'd0, 1'b0, 1'b0, rand_imm()));
		send_instr(make_instr(MISC, COPY, 3'd0, LINK_REG, 3'd0, 1'b1, 1'b0, 15'd0));
		send_instr(make_instr(CALL, ADD, 3'd2, 3'd0, 3'd3, 1'b0, 1'b1, 15'd0));
		send_instr(make_instr(MISC, COPY, 3'd5, LINK_REG, 3'd0, 1'b1, 1'b0, 15'd0));
	endtask

	task automatic random_stream();
		instr_class_t cls;
		reg_sel_t     ra;
		reg_sel_t     rd;
		reg_sel_t     last_rd;
		last_rd = '0;
		random_ready = 1'b1;
		for (int n = 0; n < 300; n++) begin
			cls = instr_class_t'($urandom_range(3));
			rd = rand_reg();
			ra = ($urandom_range(1) == 1) ? last_rd : rand_reg();
			send_instr(make_instr(cls, 4'($urandom_range(15)), rd, ra, rand_reg(),
				1'($urandom_range(1)), 1'($urandom_range(1)), rand_imm()));
			if (cls == CALL)
				last_rd = LINK_REG;
			else if (cls != BRANCH)
				last_rd = rd;
			if ($urandom_range(3) == 0)
				idle_cycles($urandom_range(1, 3));
		end
		random_ready = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		res_ready = 1'b1;
		random_ready = 1'b0;
		test_num = 0;
		errors = 0;
		errors_at_start = 0;
		tests_ok = 0;
		tests_bad = 0;
		cur_test = "reset";
		void'($urandom(32'hb621));
		for (int i = 0; i < NUM_REGS; i++)
			ref_regs[i] = '0;
		ref_c = 1'b0;
		ref_z = 1'b0;
		ref_pc = RESET_PC;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test("reset");
		reset_checks();
		finish_test();
		start_test("alu_ops");
		alu_sweep();
		finish_test();
		start_test("carry_chain");
		carry_chain();
		finish_test();
		start_test("branches");
		branch_conds();
		finish_test();
		start_test("call_link");
		call_link();
		finish_test();
		start_test("random");
		random_stream();
		finish_test();

		$display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== hdl/oldland_exec_top.sv ====
module oldland_exec_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  oldland_pkg::word_t     in_instr,
	output logic                   res_valid,
	input  logic                   res_ready,
	output oldland_pkg::word_t     res_value,
	output oldland_pkg::word_t     res_alu,
	output oldland_pkg::reg_sel_t  res_rd,
	output logic                   res_branch_taken
);

	import oldland_pkg::*;

	logic         dec_valid, dec_ready, dec_op1_ra, dec_op2_rb;
	instr_class_t dec_class;
	alu_opc_t     dec_alu;
	reg_sel_t     dec_rd, dec_ra, dec_rb;
	word_t        dec_imm, dec_pc_plus_4;

	logic         q_valid, q_ready, q_op1_ra, q_op2_rb;
	instr_class_t q_class;
	alu_opc_t     q_alu;
	reg_sel_t     q_rd, q_ra, q_rb;
	word_t        q_imm, q_pc_plus_4;

	reg_sel_t     rf_ra_sel, rf_rb_sel, rf_wr_sel;
	word_t        rf_ra_data, rf_rb_data, rf_wr_data;
	logic         rf_wr_en;

	oldland_decode i_decode (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.dec_valid(dec_valid), .dec_ready(dec_ready), .dec_class(dec_class),
		.dec_alu(dec_alu), .dec_rd(dec_rd), .dec_ra(dec_ra), .dec_rb(dec_rb),
		.dec_op1_ra(dec_op1_ra), .dec_op2_rb(dec_op2_rb), .dec_imm(dec_imm),
		.dec_pc_plus_4(dec_pc_plus_4)
	);

	oldland_issue_queue i_queue (
		.clk(clk), .reset(reset),
		.push_valid(dec_valid), .push_ready(dec_ready), .push_class(dec_class),
		.push_alu(dec_alu), .push_rd(dec_rd), .push_ra(dec_ra), .push_rb(dec_rb),
		.push_op1_ra(dec_op1_ra), .push_op2_rb(dec_op2_rb), .push_imm(dec_imm),
		.push_pc_plus_4(dec_pc_plus_4),
		.pop_valid(q_valid), .pop_ready(q_ready), .pop_class(q_class),
		.pop_alu(q_alu), .pop_rd(q_rd), .pop_ra(q_ra), .pop_rb(q_rb),
		.pop_op1_ra(q_op1_ra), .pop_op2_rb(q_op2_rb), .pop_imm(q_imm),
		.pop_pc_plus_4(q_pc_plus_4)
	);

	oldland_exec i_exec (
		.clk(clk), .reset(reset),
		.op_valid(q_valid), .op_ready(q_ready), .op_class(q_class),
		.op_alu(q_alu), .op_rd(q_rd), .op_ra(q_ra), .op_rb(q_rb),
		.op_op1_ra(q_op1_ra), .op_op2_rb(q_op2_rb), .op_imm(q_imm),
		.op_pc_plus_4(q_pc_plus_4),
		.rf_ra_sel(rf_ra_sel), .rf_rb_sel(rf_rb_sel),
		.rf_ra_data(rf_ra_data), .rf_rb_data(rf_rb_data),
		.rf_wr_en(rf_wr_en), .rf_wr_sel(rf_wr_sel), .rf_wr_data(rf_wr_data),
		.res_valid(res_valid), .res_ready(res_ready), .res_value(res_value),
		.res_alu(res_alu), .res_rd(res_rd), .res_branch_taken(res_branch_taken)
	);

	oldland_regfile i_regfile (
		.clk(clk), .reset(reset),
		.ra_sel(rf_ra_sel), .rb_sel(rf_rb_sel),
		.ra_data(rf_ra_data), .rb_data(rf_rb_data),
		.wr_en(rf_wr_en), .wr_sel(rf_wr_sel), .wr_data(rf_wr_data)
	);

endmodule

// ==== hdl/oldland_exec.sv ====
module oldland_exec (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       op_valid,
	output logic                       op_ready,
	input  oldland_pkg::instr_class_t  op_class,
	input  oldland_pkg::alu_opc_t      op_alu,
	input  oldland_pkg::reg_sel_t      op_rd,
	input  oldland_pkg::reg_sel_t      op_ra,
	input  oldland_pkg::reg_sel_t      op_rb,
	input  logic                       op_op1_ra,
	input  logic                       op_op2_rb,
	input  oldland_pkg::word_t         op_imm,
	input  oldland_pkg::word_t         op_pc_plus_4,
	output oldland_pkg::reg_sel_t      rf_ra_sel,
	output oldland_pkg::reg_sel_t      rf_rb_sel,
	input  oldland_pkg::word_t         rf_ra_data,
	input  oldland_pkg::word_t         rf_rb_data,
	output logic                       rf_wr_en,
	output oldland_pkg::reg_sel_t      rf_wr_sel,
	output oldland_pkg::word_t         rf_wr_data,
	output logic                       res_valid,
	input  logic                       res_ready,
	output oldland_pkg::word_t         res_value,
	output oldland_pkg::word_t         res_alu,
	output oldland_pkg::reg_sel_t      res_rd,
	output logic                       res_branch_taken
);

	import oldland_pkg::*;

	word_t        op1;
	word_t        op2;
	word_t        alu_q;
	logic         alu_c;
	logic         alu_z;
	logic         cond_met;
	logic         taken;
	logic         accept;
	word_t        wr_value;
	branch_cond_t cond;

	// Flags are internal state, never visible in the register file
	logic c_flag;
	logic z_flag;

	assign op_ready = !res_valid || res_ready;
	assign accept = op_valid && op_ready;

	assign rf_ra_sel = op_ra;
	assign rf_rb_sel = op_rb;

	assign op1 = op_op1_ra ? rf_ra_data : op_pc_plus_4;
	assign op2 = op_op2_rb ? rf_rb_data : op_imm;
	assign alu_z = (op1 == op2);

	always_comb begin
		alu_c = 1'b0;
		alu_q = '0;
		case (op_alu)
		ADD:   {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ADDC:  {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, c_flag};
		SUB:   {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		SUBC:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + {32'b0, c_flag};
		LSL:   {alu_c, alu_q} = {1'b0, op1} << op2[4:0];
		LSR:   alu_q = op1 >> op2[4:0];
		AND:   alu_q = op1 & op2;
		XOR:   alu_q = op1 ^ op2;
		BIC:   alu_q = op1 & ~(32'd1 << op2[4:0]);
		BST:   alu_q = op1 | (32'd1 << op2[4:0]);
		OR:    alu_q = op1 | op2;
		MOVHI: alu_q = {1'b0, op_imm[14:0], 16'h0000};
		CLR:   alu_q = '0;
		ASR:   alu_q = $signed(op1) >>> op2[4:0];
		COPY:  alu_q = op1;
		default: alu_q = '0;
		endcase
	end

	assign cond = branch_cond_t'(op_rd);

	always_comb begin
		case (cond)
		ALWAYS:  cond_met = 1'b1;
		NE:      cond_met = !z_flag;
		EQ:      cond_met = z_flag;
		CC:      cond_met = !c_flag;
		CS:      cond_met = c_flag;
		default: cond_met = 1'b0;
		endcase
	end

	assign taken = (op_class == BRANCH) && cond_met;
	assign wr_value = (op_class == CALL) ? op_pc_plus_4 : alu_q;

	assign rf_wr_en = accept && (op_class != BRANCH);
	assign rf_wr_sel = op_rd;
	assign rf_wr_data = wr_value;

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			c_flag <= 1'b0;
			z_flag <= 1'b0;
		end else begin
			if (accept)
				res_valid <= 1'b1;
			else if (res_ready)
				res_valid <= 1'b0;
			if (accept && op_class == ARITH) begin
				c_flag <= alu_c;
				z_flag <= alu_z;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			res_value <= wr_value;
			res_alu <= alu_q;
			res_rd <= op_rd;
			res_branch_taken <= taken;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		res_valid && !res_ready |=> res_valid && $stable(res_value))
		else $error("result changed while stalled");

endmodule

// ==== hdl/oldland_regfile.sv ====
module oldland_regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  oldland_pkg::reg_sel_t  ra_sel,
	input  oldland_pkg::reg_sel_t  rb_sel,
	output oldland_pkg::word_t     ra_data,
	output oldland_pkg::word_t     rb_data,
	input  logic                   wr_en,
	input  oldland_pkg::reg_sel_t  wr_sel,
	input  oldland_pkg::word_t     wr_data
);

	import oldland_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Reads see the old value when the same register is written this cycle
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

endmodule

// ==== hdl/oldland_issue_queue.sv ====
module oldland_issue_queue (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       push_valid,
	output logic                       push_ready,
	input  oldland_pkg::instr_class_t  push_class,
	input  oldland_pkg::alu_opc_t      push_alu,
	input  oldland_pkg::reg_sel_t      push_rd,
	input  oldland_pkg::reg_sel_t      push_ra,
	input  oldland_pkg::reg_sel_t      push_rb,
	input  logic                       push_op1_ra,
	input  logic                       push_op2_rb,
	input  oldland_pkg::word_t         push_imm,
	input  oldland_pkg::word_t         push_pc_plus_4,
	output logic                       pop_valid,
	input  logic                       pop_ready,
	output oldland_pkg::instr_class_t  pop_class,
	output oldland_pkg::alu_opc_t      pop_alu,
	output oldland_pkg::reg_sel_t      pop_rd,
	output oldland_pkg::reg_sel_t      pop_ra,
	output oldland_pkg::reg_sel_t      pop_rb,
	output logic                       pop_op1_ra,
	output logic                       pop_op2_rb,
	output oldland_pkg::word_t         pop_imm,
	output oldland_pkg::word_t         pop_pc_plus_4
);

	import oldland_pkg::*;

	instr_class_t     q_class [QUEUE_DEPTH];
	alu_opc_t         q_alu [QUEUE_DEPTH];
	reg_sel_t         q_rd [QUEUE_DEPTH];
	reg_sel_t         q_ra [QUEUE_DEPTH];
	reg_sel_t         q_rb [QUEUE_DEPTH];
	logic             q_op1_ra [QUEUE_DEPTH];
	logic             q_op2_rb [QUEUE_DEPTH];
	word_t            q_imm [QUEUE_DEPTH];
	word_t            q_pc_plus_4 [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0]   count;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == QUEUE_DEPTH);
	assign pop_valid = (count != 0);
	// When full, a pop in the same cycle frees the slot being written
	assign push_ready = !full || pop_ready;
	assign push = push_valid && push_ready;
	assign pop = pop_valid && pop_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_class[wr_ptr] <= push_class;
			q_alu[wr_ptr] <= push_alu;
			q_rd[wr_ptr] <= push_rd;
			q_ra[wr_ptr] <= push_ra;
			q_rb[wr_ptr] <= push_rb;
			q_op1_ra[wr_ptr] <= push_op1_ra;
			q_op2_rb[wr_ptr] <= push_op2_rb;
			q_imm[wr_ptr] <= push_imm;
			q_pc_plus_4[wr_ptr] <= push_pc_plus_4;
		end
	end

	assign pop_class = q_class[rd_ptr];
	assign pop_alu = q_alu[rd_ptr];
	assign pop_rd = q_rd[rd_ptr];
	assign pop_ra = q_ra[rd_ptr];
	assign pop_rb = q_rb[rd_ptr];
	assign pop_op1_ra = q_op1_ra[rd_ptr];
	assign pop_op2_rb = q_op2_rb[rd_ptr];
	assign pop_imm = q_imm[rd_ptr];
	assign pop_pc_plus_4 = q_pc_plus_4[rd_ptr];

	assert property (@(posedge clk) disable iff (reset)
		push && full |=> count == QUEUE_DEPTH)
		else $error("push into a full queue changed its fill level");

	assert property (@(posedge clk) disable iff (reset)
		count <= QUEUE_DEPTH)
		else $error("queue count above depth");

endmodule

// ==== hdl/oldland_decode.sv ====
module oldland_decode (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  oldland_pkg::word_t         in_instr,
	output logic                       dec_valid,
	input  logic                       dec_ready,
	output oldland_pkg::instr_class_t  dec_class,
	output oldland_pkg::alu_opc_t      dec_alu,
	output oldland_pkg::reg_sel_t      dec_rd,
	output oldland_pkg::reg_sel_t      dec_ra,
	output oldland_pkg::reg_sel_t      dec_rb,
	output logic                       dec_op1_ra,
	output logic                       dec_op2_rb,
	output oldland_pkg::word_t         dec_imm,
	output oldland_pkg::word_t         dec_pc_plus_4
);

	import oldland_pkg::*;

	instr_class_t in_class;
	reg_sel_t     in_rd;
	word_t        in_imm;
	word_t        pc;
	logic         accept;

	assign in_ready = !dec_valid || dec_ready;
	assign accept = in_valid && in_ready;

	assign in_class = instr_class_t'(in_instr[31:30]);

	// For a branch the rd field carries the condition code and passes through as is
	assign in_rd = (in_class == CALL) ? LINK_REG : in_instr[25:23];
	assign in_imm = {{17{in_instr[14]}}, in_instr[14:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			pc <= RESET_PC;
		end else begin
			if (accept) begin
				dec_valid <= 1'b1;
				pc <= pc + 32'd4;
			end else if (dec_ready) begin
				dec_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_class <= in_class;
			dec_alu <= alu_opc_t'(in_instr[29:26]);
			dec_rd <= in_rd;
			dec_ra <= in_instr[22:20];
			dec_rb <= in_instr[19:17];
			dec_op1_ra <= in_instr[16];
			dec_op2_rb <= in_instr[15];
			dec_imm <= in_imm;
			dec_pc_plus_4 <= pc + 32'd4;
		end
	end

	// A stalled op must not change under the queue
	assert property (@(posedge clk) disable iff (reset)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_class) &&
			$stable(dec_alu) && $stable(dec_rd) && $stable(dec_ra) &&
			$stable(dec_rb) && $stable(dec_op1_ra) && $stable(dec_op2_rb) &&
			$stable(dec_imm) && $stable(dec_pc_plus_4))
		else $error("decode output changed while stalled");

endmodule

// ==== hdl/oldland_pkg.sv ====
package oldland_pkg;

	typedef enum logic [3:0] {
		ADD   = 4'd0,
		ADDC  = 4'd1,
		SUB   = 4'd2,
		SUBC  = 4'd3,
		LSL   = 4'd4,
		LSR   = 4'd5,
		AND   = 4'd6,
		XOR   = 4'd7,
		BIC   = 4'd8,
		BST   = 4'd9,
		OR    = 4'd10,
		MOVHI = 4'd11,
		CLR   = 4'd12,
		ASR   = 4'd14,
		COPY  = 4'd15
	} alu_opc_t;

	// Only ARITH touches the carry and zero flags
	typedef enum logic [1:0] {
		ARITH  = 2'd0,
		BRANCH = 2'd1,
		CALL   = 2'd2,
		MISC   = 2'd3
	} instr_class_t;

	typedef enum logic [2:0] {
		NEVER  = 3'd0,
		NE     = 3'd1,
		EQ     = 3'd2,
		CC     = 3'd3,
		CS     = 3'd4,
		ALWAYS = 3'd7
	} branch_cond_t;

	typedef logic [2:0] reg_sel_t;
	typedef logic [31:0] word_t;

	localparam int NUM_REGS = 8;
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam reg_sel_t LINK_REG = 3'd7;
	localparam word_t RESET_PC = 32'h0000_0000;

endpackage
